/* include/overlay_consts.svh */
// frame geometry, coordinate and pixel widths, and output pipeline depth
`ifndef OVERLAY_CONSTS_SVH
`define OVERLAY_CONSTS_SVH

// horizontal timing in quads
`define OVL_H_ACTIVE 16
`define OVL_H_TOTAL 24
`define OVL_H_WINDOW 18    // hsync stays high two quads past de

// vertical timing in quad rows
`define OVL_V_ACTIVE 8
`define OVL_V_TOTAL 12

// quad coordinate width, enough for OVL_H_TOTAL
`define OVL_POS_W 5

// bits per pixel
`define OVL_PIX_W 8

// cycles from tim_pos to out_beat
// one for the generators, two for the merge
`define OVL_PIPE_DEPTH 3

`endif

/* design/overlay_pkg.sv */
// stream and settings types: quad, stream beat, quad position, box settings
`include "overlay_consts.svh"

package overlay_pkg;

	// one 2x2 quad, p00 is top left
	typedef struct packed
	{
		logic [`OVL_PIX_W-1:0] p00;
		logic [`OVL_PIX_W-1:0] p01;
		logic [`OVL_PIX_W-1:0] p10;
		logic [`OVL_PIX_W-1:0] p11;
	} quad_t;

	// one stream cycle
	typedef struct packed
	{
		logic  de;
		logic  valid;
		logic  hsync;
		logic  vsync;
		quad_t pix;
	} beat_t;

	// position in quad units
	typedef struct packed
	{
		logic [`OVL_POS_W-1:0] x;
		logic [`OVL_POS_W-1:0] y;
	} pos_t;

	// box corners, both inclusive
	typedef struct packed
	{
		logic [`OVL_POS_W-1:0] x0;
		logic [`OVL_POS_W-1:0] y0;
		logic [`OVL_POS_W-1:0] x1;
		logic [`OVL_POS_W-1:0] y1;
		logic [`OVL_PIX_W-1:0] colour;  // outline value, nonzero to be seen
	} box_cfg_t;

endpackage

/* design/video_timing_gen.sv */
// video timing generator: h/v quad counters, stream levels, quad position, frame start
`timescale 1ns/10ps
`include "overlay_consts.svh"

module video_timing_gen
(
	input  logic               out_clk,
	input  logic               rstn,
	input  logic               stream_en,
	output overlay_pkg::beat_t tim_beat,
	output overlay_pkg::pos_t  tim_pos,
	output logic               frame_start
);

	logic [`OVL_POS_W-1:0] h_cnt;
	logic [`OVL_POS_W-1:0] v_cnt;
	logic                  h_last;
	logic                  v_last;
	logic                  de_c;

	assign h_last = (h_cnt == `OVL_POS_W'(`OVL_H_TOTAL - 1));
	assign v_last = (v_cnt == `OVL_POS_W'(`OVL_V_TOTAL - 1));
	assign de_c   = (h_cnt < `OVL_H_ACTIVE) && (v_cnt < `OVL_V_ACTIVE);

	// counters leave reset on the last quad so the first step wraps into frame 0
	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			h_cnt <= `OVL_POS_W'(`OVL_H_TOTAL - 1);
			v_cnt <= `OVL_POS_W'(`OVL_V_TOTAL - 1);
		end
		else
		begin
			if (h_last)
			begin
				h_cnt <= '0;
				if (v_last)
				begin
					v_cnt <= '0;
				end
				else
				begin
					v_cnt <= v_cnt + 1'b1;
				end
			end
			else
			begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// registered outputs, one cycle behind the counters
	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			tim_beat    <= '0;
			tim_pos     <= '0;
			frame_start <= 1'b0;
		end
		else
		begin
			tim_beat.de    <= de_c;
			tim_beat.valid <= de_c & stream_en;
			tim_beat.hsync <= (h_cnt < `OVL_H_WINDOW);
			tim_beat.vsync <= (v_cnt < `OVL_V_ACTIVE);
			tim_beat.pix   <= '0;         // generators fill the pixels
			tim_pos.x      <= h_cnt;
			tim_pos.y      <= v_cnt;
			// high while the counters sit at 0,0, one cycle ahead of quad 0,0 on tim_beat
			frame_start    <= h_last && v_last;
		end
	end

	a_de_in_window: assert property (@(posedge out_clk) disable iff (!rstn)
		$rose(tim_beat.de) |-> (tim_beat.hsync && tim_beat.vsync && (tim_pos.x == '0)))
		else $error("de rose outside the hsync/vsync window or away from quad x 0");

endmodule

/* design/overlay_ctrl.sv */
// frame-synchronous box settings FSM with shadow and active registers
`timescale 1ns/10ps

module overlay_ctrl
(
	input  logic                  out_clk,
	input  logic                  rstn,
	input  overlay_pkg::box_cfg_t cfg_box,
	input  logic                  cfg_load,
	input  logic                  overlay_en,
	input  logic                  frame_start,
	output overlay_pkg::box_cfg_t act_box,
	output logic                  box_show
);

	typedef enum logic [1:0]
	{
		ST_OFF,
		ST_PENDING,
		ST_SHOW
	} state_t;

	state_t                state;
	state_t                state_nxt;
	overlay_pkg::box_cfg_t shadow;     // settings waiting for the next frame
	logic                  en_q;
	logic                  change;
	logic                  apply;

	assign change = cfg_load || (overlay_en != en_q);
	assign apply  = (state == ST_PENDING) && frame_start;

	always_comb
	begin
		state_nxt = state;
		if (apply)
		begin
			state_nxt = overlay_en ? ST_SHOW : ST_OFF;
		end
		// a new request always wins, even in the frame start cycle
		if (change)
		begin
			state_nxt = ST_PENDING;
		end
	end

	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state    <= ST_OFF;
			en_q     <= 1'b0;
			shadow   <= '0;
			act_box  <= '0;
			box_show <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			en_q  <= overlay_en;
			if (cfg_load)
			begin
				shadow <= cfg_box;
			end
			if (apply)
			begin
				act_box  <= shadow;
				box_show <= overlay_en;   // held through PENDING until the switch
			end
		end
	end

	// outside PENDING the shown flag must match the settled state
	a_show_matches_state: assert property (@(posedge out_clk) disable iff (!rstn)
		(state != ST_PENDING) |-> (box_show == (state == ST_SHOW)))
		else $error("box_show disagrees with the FSM state");

endmodule

/* design/pattern_gen.sv */
// main stream pattern generator, pixels from the quad position
`timescale 1ns/10ps
`include "overlay_consts.svh"

module pattern_gen
(
	input  logic               out_clk,
	input  logic               rstn,
	input  overlay_pkg::beat_t tim_beat,
	input  overlay_pkg::pos_t  tim_pos,
	output overlay_pkg::beat_t main_beat
);

	logic [`OVL_PIX_W-1:0] base;

	// 64*y + 4*x, wraps to pixel width
	assign base = `OVL_PIX_W'(tim_pos.y * 64 + tim_pos.x * 4);

	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			main_beat <= '0;
		end
		else
		begin
			main_beat.de    <= tim_beat.de;
			main_beat.valid <= tim_beat.valid;
			main_beat.hsync <= tim_beat.hsync;
			main_beat.vsync <= tim_beat.vsync;
			if (tim_beat.de)
			begin
				main_beat.pix.p00 <= base;
				main_beat.pix.p01 <= base + `OVL_PIX_W'(1);
				main_beat.pix.p10 <= base + `OVL_PIX_W'(2);
				main_beat.pix.p11 <= base + `OVL_PIX_W'(3);
			end
			else
			begin
				main_beat.pix <= '0;     // blanking
			end
		end
	end

endmodule

/* design/overlay_box_gen.sv */
// overlay stream generator, draws the active box outline
`timescale 1ns/10ps

module overlay_box_gen
(
	input  logic                  out_clk,
	input  logic                  rstn,
	input  overlay_pkg::beat_t    tim_beat,
	input  overlay_pkg::pos_t     tim_pos,
	input  overlay_pkg::box_cfg_t act_box,
	input  logic                  box_show,
	output overlay_pkg::beat_t    ovl_beat
);

	logic in_x;     // x within x0..x1
	logic in_y;     // y within y0..y1
	logic on_row;
	logic on_col;
	logic hit;

	assign in_x = (tim_pos.x >= act_box.x0) && (tim_pos.x <= act_box.x1);
	assign in_y = (tim_pos.y >= act_box.y0) && (tim_pos.y <= act_box.y1);

	// top or bottom edge
	assign on_row = ((tim_pos.y == act_box.y0) || (tim_pos.y == act_box.y1)) && in_x;
	// left or right edge
	assign on_col = ((tim_pos.x == act_box.x0) || (tim_pos.x == act_box.x1)) && in_y;

	assign hit = box_show && tim_beat.de && (on_row || on_col);

	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			ovl_beat <= '0;
		end
		else
		begin
			ovl_beat.de    <= tim_beat.de;
			ovl_beat.valid <= tim_beat.de;    // overlay ignores stream_en
			ovl_beat.hsync <= tim_beat.hsync;
			ovl_beat.vsync <= tim_beat.vsync;
			if (hit)
			begin
				ovl_beat.pix <= {4{act_box.colour}};
			end
			else
			begin
				ovl_beat.pix <= '0;   // transparent
			end
		end
	end

endmodule

/* design/overlay_merge.sv */
// two-stage per-pixel merge of main and overlay streams
`timescale 1ns/10ps

module overlay_merge
(
	input  logic               out_clk,
	input  logic               rstn,
	input  overlay_pkg::beat_t main_beat,
	input  overlay_pkg::beat_t ovl_beat,
	output overlay_pkg::beat_t out_beat
);

	overlay_pkg::beat_t main_q;
	overlay_pkg::quad_t ovl_pix_q;
	logic               check_q;   // main beat in active video and valid
	logic [3:0]         nz_q;      // overlay pixel nonzero, bit 0 is p00

	// stage 1
	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			main_q    <= '0;
			ovl_pix_q <= '0;
			check_q   <= 1'b0;
			nz_q      <= '0;
		end
		else
		begin
			main_q    <= main_beat;
			ovl_pix_q <= ovl_beat.pix;
			check_q   <= main_beat.valid & main_beat.hsync & main_beat.vsync & main_beat.de;
			nz_q[0]   <= (ovl_beat.pix.p00 != '0);
			nz_q[1]   <= (ovl_beat.pix.p01 != '0);
			nz_q[2]   <= (ovl_beat.pix.p10 != '0);
			nz_q[3]   <= (ovl_beat.pix.p11 != '0);
		end
	end

	// stage 2
	always_ff @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			out_beat <= '0;
		end
		else
		begin
			out_beat.de    <= main_q.de;
			out_beat.valid <= main_q.valid;
			out_beat.hsync <= main_q.hsync;
			out_beat.vsync <= main_q.vsync;
			// overlay wins per pixel only where it is opaque
			out_beat.pix.p00 <= (check_q && nz_q[0]) ? ovl_pix_q.p00 : main_q.pix.p00;
			out_beat.pix.p01 <= (check_q && nz_q[1]) ? ovl_pix_q.p01 : main_q.pix.p01;
			out_beat.pix.p10 <= (check_q && nz_q[2]) ? ovl_pix_q.p10 : main_q.pix.p10;
			out_beat.pix.p11 <= (check_q && nz_q[3]) ? ovl_pix_q.p11 : main_q.pix.p11;
		end
	end

	// both generators must present the same quad in the same cycle
	a_streams_aligned: assert property (@(posedge out_clk) disable iff (!rstn)
		{ovl_beat.de, ovl_beat.hsync, ovl_beat.vsync}
			== {main_beat.de, main_beat.hsync, main_beat.vsync})
		else $error("main and overlay streams out of step");

	a_valid_in_de: assert property (@(posedge out_clk) disable iff (!rstn)
		out_beat.valid |-> out_beat.de)
		else $error("out valid without de");

endmodule

/* design/overlay_subsys_top.sv */
// overlay subsystem top: timing, settings FSM, pattern and box generators, merge
`timescale 1ns/10ps

module overlay_subsys_top
(
	input  logic                  out_clk,
	input  logic                  rstn,
	input  logic                  stream_en,
	input  overlay_pkg::box_cfg_t cfg_box,
	input  logic                  cfg_load,
	input  logic                  overlay_en,
	output overlay_pkg::beat_t    out_beat
);

	overlay_pkg::beat_t    tim_beat;   // levels only, zero quad
	overlay_pkg::pos_t     tim_pos;
	logic                  frame_start;
	overlay_pkg::box_cfg_t act_box;
	logic                  box_show;
	overlay_pkg::beat_t    main_beat;
	overlay_pkg::beat_t    ovl_beat;

	video_timing_gen u_timing
	(
		.out_clk     (out_clk),
		.rstn        (rstn),
		.stream_en   (stream_en),
		.tim_beat    (tim_beat),
		.tim_pos     (tim_pos),
		.frame_start (frame_start)
	);

	overlay_ctrl u_ctrl
	(
		.out_clk     (out_clk),
		.rstn        (rstn),
		.cfg_box     (cfg_box),
		.cfg_load    (cfg_load),
		.overlay_en  (overlay_en),
		.frame_start (frame_start),
		.act_box     (act_box),
		.box_show    (box_show)
	);

	pattern_gen u_pattern
	(
		.out_clk   (out_clk),
		.rstn      (rstn),
		.tim_beat  (tim_beat),
		.tim_pos   (tim_pos),
		.main_beat (main_beat)
	);

	overlay_box_gen u_box
	(
		.out_clk  (out_clk),
		.rstn     (rstn),
		.tim_beat (tim_beat),
		.tim_pos  (tim_pos),
		.act_box  (act_box),
		.box_show (box_show),
		.ovl_beat (ovl_beat)
	);

	overlay_merge u_merge
	(
		.out_clk   (out_clk),
		.rstn      (rstn),
		.main_beat (main_beat),
		.ovl_beat  (ovl_beat),
		.out_beat  (out_beat)
	);

endmodule

/* sim/tb_overlay_subsys.sv */
// testbench for the overlay subsystem: clock, reset, stimulus, reference model, assertions, watchdog
`timescale 1ns/10ps
`include "overlay_consts.svh"

module tb_overlay_subsys;

	localparam int CLK_PERIOD   = 20;   // ns
	localparam int FRAME_CYCLES = `OVL_H_TOTAL * `OVL_V_TOTAL;
	localparam int NUM_FRAMES   = 15;
	localparam int WATCHDOG_NS  = (NUM_FRAMES + 2) * FRAME_CYCLES * CLK_PERIOD;
	localparam logic [31:0] SEED = 32'hd50cd875;

	logic                  out_clk;
	logic                  rstn;
	logic                  stream_en;
	overlay_pkg::box_cfg_t cfg_box;
	logic                  cfg_load;
	logic                  overlay_en;
	overlay_pkg::beat_t    out_beat;

	// requested settings, and the ones in force for the frame on out_beat
	overlay_pkg::box_cfg_t req_box;
	logic                  req_show;
	logic                  req_stream;
	overlay_pkg::box_cfg_t frm_box;
	logic                  frm_show;
	logic                  frm_stream;

	// position of the quad on out_beat, locked to the first vsync rise
	int                    th;
	int                    tv;
	int                    cur_h;
	int                    cur_v;
	logic                  synced;
	logic                  synced_now;
	logic                  prev_vs;
	logic                  vs_rise;
	int                    rst_cycles = 0;
	int                    run_cycles = 0;   // rising edges since reset release
	logic [31:0]           rng;

	logic                  exp_de;
	logic                  exp_valid;
	logic                  exp_hsync;
	logic                  exp_vsync;
	logic                  use_box;
	overlay_pkg::quad_t    exp_pix;

	overlay_subsys_top UUT
	(
		.out_clk    (out_clk),
		.rstn       (rstn),
		.stream_en  (stream_en),
		.cfg_box    (cfg_box),
		.cfg_load   (cfg_load),
		.overlay_en (overlay_en),
		.out_beat   (out_beat)
	);

	always #(CLK_PERIOD / 2) out_clk = ~out_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		begin
			v = s;
			v = v ^ (v << 13);
			v = v ^ (v >> 17);
			v = v ^ (v << 5);
			return v;
		end
	endfunction

	// pattern value: 64*y + 4*x + s, kept to 8 bits
	function automatic logic [7:0] pattern_value(input int x, input int y, input int s);
		return 8'((y * 64 + x * 4 + s) % 256);
	endfunction

	function automatic logic outline_hit(input overlay_pkg::box_cfg_t b, input int x, input int y);
		logic span_x;
		logic span_y;
		logic edge_row;
		logic edge_col;
		begin
			span_x   = (x >= int'(b.x0)) && (x <= int'(b.x1));
			span_y   = (y >= int'(b.y0)) && (y <= int'(b.y1));
			edge_row = (y == int'(b.y0)) || (y == int'(b.y1));
			edge_col = (x == int'(b.x0)) || (x == int'(b.x1));
			return (edge_row && span_x) || (edge_col && span_y);
		end
	endfunction

	// shape 1 flat row, 2 single column, 3 single quad
	function automatic overlay_pkg::box_cfg_t make_box(input logic [31:0] r, input int shape);
		overlay_pkg::box_cfg_t b;
		logic [`OVL_POS_W-1:0]  xa;
		logic [`OVL_POS_W-1:0]  xb;
		logic [`OVL_POS_W-1:0]  ya;
		logic [`OVL_POS_W-1:0]  yb;
		logic [`OVL_PIX_W-1:0]  c;
		begin
			xa = {1'b0, r[3:0]};
			xb = {1'b0, r[7:4]};
			ya = {2'b00, r[10:8]};
			yb = {2'b00, r[13:11]};
			c  = r[23:16];
			b.x0 = (xa < xb) ? xa : xb;
			b.x1 = (xa < xb) ? xb : xa;
			b.y0 = (ya < yb) ? ya : yb;
			b.y1 = (ya < yb) ? yb : ya;
			if ((shape == 1) || (shape == 3))
			begin
				b.y1 = b.y0;
			end
			if ((shape == 2) || (shape == 3))
			begin
				b.x1 = b.x0;
			end
			b.colour = (c == 8'h00) ? 8'h01 : c;   // colour zero would be transparent
			return b;
		end
	endfunction

	always_comb
	begin
		vs_rise    = out_beat.vsync && !prev_vs;
		cur_h      = vs_rise ? 0 : th;
		cur_v      = vs_rise ? 0 : tv;
		synced_now = synced || vs_rise;
		exp_de     = synced_now && (cur_h < `OVL_H_ACTIVE) && (cur_v < `OVL_V_ACTIVE);
		exp_hsync  = synced_now && (cur_h < `OVL_H_WINDOW);
		exp_vsync  = synced_now && (cur_v < `OVL_V_ACTIVE);
		exp_valid  = exp_de && frm_stream;
		use_box    = exp_valid && frm_show && outline_hit(frm_box, cur_h, cur_v);
		exp_pix    = '0;
		if (use_box)
		begin
			exp_pix = {4{frm_box.colour}};
		end
		else if (exp_de)
		begin
			exp_pix.p00 = pattern_value(cur_h, cur_v, 0);
			exp_pix.p01 = pattern_value(cur_h, cur_v, 1);
			exp_pix.p10 = pattern_value(cur_h, cur_v, 2);
			exp_pix.p11 = pattern_value(cur_h, cur_v, 3);
		end
	end

	always @(posedge out_clk or negedge rstn)
	begin
		if (!rstn)
		begin
			prev_vs <= 1'b0;
			synced  <= 1'b0;
			th      <= 0;
			tv      <= 0;
		end
		else
		begin
			prev_vs <= out_beat.vsync;
			if (synced_now)
			begin
				synced <= 1'b1;
				th     <= (cur_h == `OVL_H_TOTAL - 1) ? 0 : cur_h + 1;
				if (cur_h == `OVL_H_TOTAL - 1)
				begin
					tv <= (cur_v == `OVL_V_TOTAL - 1) ? 0 : cur_v + 1;
				end
			end
		end
	end

	// settings freeze once vsync rises
	always @(posedge out_clk)
	begin
		if (!out_beat.vsync)
		begin
			frm_box    <= req_box;
			frm_show   <= req_show;
			frm_stream <= req_stream;
		end
		if (!rstn)
		begin
			rst_cycles <= rst_cycles + 1;
		end
		else
		begin
			run_cycles <= run_cycles + 1;
		end
	end

	task automatic report_failure(input string what);
		begin
			$display("[FAIL] %0t ns: %s at quad h %0d v %0d", $time, what, cur_h, cur_v);
			$display("TEST FAILED");
			$fatal(1, "output check failed");
		end
	endtask

	a_reset_quiet: assert property (@(posedge out_clk)
		(!rstn && (rst_cycles != 0)) |-> (out_beat == '0))
		else report_failure("output not zero during reset");

	// one step out of reset and one timing register, then the pipeline
	a_first_latency: assert property (@(posedge out_clk) disable iff (!rstn)
		(vs_rise && !synced) |-> (run_cycles == `OVL_PIPE_DEPTH + 2))
		else report_failure("first frame reached out_beat at the wrong cycle");

	a_levels: assert property (@(posedge out_clk) disable iff (!rstn)
		{out_beat.de, out_beat.valid, out_beat.hsync, out_beat.vsync}
			== {exp_de, exp_valid, exp_hsync, exp_vsync})
		else report_failure("stream levels off the window rules");

	a_pixels: assert property (@(posedge out_clk) disable iff (!rstn)
		out_beat.pix == exp_pix)
		else report_failure("pixel quad differs from the model");

	a_frame_period: assert property (@(posedge out_clk) disable iff (!rstn)
		(vs_rise && synced) |-> ((th == 0) && (tv == 0)))
		else report_failure("vsync rose away from the frame boundary");

	// returns just after the first cycle of vertical blanking on out_beat
	task automatic wait_vblank();
		begin
			@(negedge out_beat.vsync);
			@(posedge out_clk);
			#2;
		end
	endtask

	task automatic load_box(input overlay_pkg::box_cfg_t b);
		begin
			cfg_box  = b;
			cfg_load = 1'b1;
			req_box  = b;
			@(posedge out_clk);
			#2;
			cfg_load = 1'b0;
			cfg_box  = ~b;    // bus moves on, only the strobe captures
		end
	endtask

	task automatic set_overlay(input logic en);
		begin
			overlay_en = en;
			req_show   = en;
		end
	endtask

	task automatic set_stream(input logic en);
		begin
			stream_en  = en;
			req_stream = en;
		end
	endtask

	initial
	begin
		int                    i;
		overlay_pkg::box_cfg_t box_a;
		overlay_pkg::box_cfg_t box_b;
		overlay_pkg::box_cfg_t box_c;
		out_clk    = 1'b0;
		rstn       = 1'b0;
		stream_en  = 1'b1;
		overlay_en = 1'b0;
		cfg_load   = 1'b0;
		cfg_box    = '0;
		req_box    = '0;
		req_show   = 1'b0;
		req_stream = 1'b1;
		rng        = SEED;
		box_a      = '{x0: 5'd3, y0: 5'd2, x1: 5'd10, y1: 5'd5, colour: 8'hf0};
		box_b      = '{x0: 5'd0, y0: 5'd0, x1: 5'd15, y1: 5'd7, colour: 8'h5a};
		box_c      = '{x0: 5'd6, y0: 5'd1, x1: 5'd12, y1: 5'd6, colour: 8'h81};
		repeat (4) @(posedge out_clk);
		#2;
		rstn = 1'b1;

		wait_vblank();            // frame 0 pattern only
		load_box(box_a);
		set_overlay(1'b1);
		wait_vblank();            // frame 1 shows box a
		load_box(box_b);
		wait_vblank();            // frame 2 full-frame border
		set_overlay(1'b0);
		wait_vblank();
		load_box(box_c);          // loaded while off, still hidden
		wait_vblank();
		set_overlay(1'b1);
		set_stream(1'b0);         // box c in force but check flag clear
		wait_vblank();
		set_stream(1'b1);

		for (i = 0; i < 8; i++)
		begin
			wait_vblank();
			rng = xorshift(rng);
			load_box(make_box(rng, (i < 4) ? i : 0));
		end
		wait_vblank();

		$display("TEST PASSED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the last frame was checked");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

/* overlay_subsys_top.f */
+incdir+include
design/overlay_pkg.sv
design/video_timing_gen.sv
design/overlay_ctrl.sv
design/pattern_gen.sv
design/overlay_box_gen.sv
design/overlay_merge.sv
design/overlay_subsys_top.sv
sim/tb_overlay_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build the overlay subsystem testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_overlay_subsys -f overlay_subsys_top.f &&
./obj_dir/Vtb_overlay_subsys || { echo "simulation failed"; exit 1; }
